//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_int_exec
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
verilog/ooo_pkg.sv
verilog/issue_if.sv
verilog/cdb_if.sv
verilog/int_issue_queue.sv
verilog/int_alu.sv
verilog/int_exec_top.sv
tb/int_exec_asserts.sv
tb/tb_int_exec.sv

//--- tb/int_exec_asserts.sv
`timescale 1ns/10ps

// handshake and bus rules of the execution cluster
module int_exec_asserts #(
   parameter int QUEUE_DEPTH = ooo_pkg::QUEUE_DEPTH_DEFAULT
) (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   dispatch_en,
   input logic                   dispatch_ready,
   input ooo_pkg::tag_t          top_rd_tag,
   input logic [QUEUE_DEPTH-1:0] q_valid,
   input logic                   issue_ready,
   input logic                   issue_done,
   input ooo_pkg::tag_t          ext_cdb_tag,
   input ooo_pkg::word_t         ext_cdb_data,
   input logic                   ext_cdb_valid,
   input ooo_pkg::tag_t          cdb_tag,
   input ooo_pkg::word_t         cdb_data,
   input logic                   cdb_valid
);

   // the bus stays quiet in reset and on the first edge after it
   reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !cdb_valid)
      else $error("cdb_valid is high during or right after reset");

   // a refused dispatch leaves the full queue untouched
   no_accept_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      dispatch_en && !dispatch_ready |=> $stable(top_rd_tag) && $stable(q_valid))
      else $error("a dispatch was taken while dispatch_ready was low");

   ext_priority: assert property (@(posedge clk) disable iff (!rst_n)
      ext_cdb_valid |-> cdb_valid && cdb_tag == ext_cdb_tag && cdb_data == ext_cdb_data)
      else $error("merged bus differs from the external broadcast");

   // entries leave the queue only through an issue handshake
   leave_only_on_issue: assert property (@(posedge clk) disable iff (!rst_n)
      !(issue_ready && issue_done) |=> $countones(q_valid) >= $countones($past(q_valid)))
      else $error("an entry left the queue without an issue handshake");

endmodule

bind int_exec_top int_exec_asserts #(
   .QUEUE_DEPTH (QUEUE_DEPTH)
) u_asserts (
   .clk            (clk),
   .rst_n          (rst_n),
   .dispatch_en    (dispatch_en),
   .dispatch_ready (dispatch_ready),
   .top_rd_tag     (u_queue.q_rd_tag[QUEUE_DEPTH-1]),
   .q_valid        (u_queue.q_valid),
   .issue_ready    (issue_bus.ready),
   .issue_done     (issue_bus.done),
   .ext_cdb_tag    (ext_cdb_tag),
   .ext_cdb_data   (ext_cdb_data),
   .ext_cdb_valid  (ext_cdb_valid),
   .cdb_tag        (cdb_tag),
   .cdb_data       (cdb_data),
   .cdb_valid      (cdb_valid)
);

//--- tb/tb_int_exec.sv
`timescale 1ns/10ps

module tb_int_exec;

   localparam int QUEUE_DEPTH = ooo_pkg::QUEUE_DEPTH_DEFAULT;
   localparam int NUM_RANDOM  = 200;

   logic             clk;
   logic             rst_n;
   ooo_pkg::opcode_t dispatch_opcode;
   ooo_pkg::tag_t    dispatch_rd_tag;
   ooo_pkg::tag_t    dispatch_rs_tag;
   ooo_pkg::tag_t    dispatch_rt_tag;
   ooo_pkg::word_t   dispatch_rs_data;
   ooo_pkg::word_t   dispatch_rt_data;
   logic             dispatch_rs_valid;
   logic             dispatch_rt_valid;
   logic             dispatch_en;
   logic             dispatch_ready;
   ooo_pkg::tag_t    ext_cdb_tag;
   ooo_pkg::word_t   ext_cdb_data;
   logic             ext_cdb_valid;
   ooo_pkg::tag_t    cdb_tag;
   ooo_pkg::word_t   cdb_data;
   logic             cdb_valid;

   // the scoreboard keeps in val the value each allocated tag is expected to carry
   ooo_pkg::word_t   val [64];
   logic             busy [64];
   int               ext_q[$];
   int               history[$];
   int               seed = 32'ha343;
   int               next_tag = 0;
   int               n_disp = 0;
   int               cycles = 0;
   int               ext_hold = 0;
   int               release_pct = 100;
   logic             saw_full = 1'b0;

   int_exec_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input ooo_pkg::tag_t t, input ooo_pkg::word_t got,
                             input ooo_pkg::word_t exp);
      if (got !== exp)
         stop_run($sformatf("[FAIL] %0t ns: tag %0d carried %h, expected %h",
                            $time, t, got, exp));
   endtask

   task automatic check_tag(input ooo_pkg::tag_t got);
      if (busy[got] !== 1'b1)
         stop_run($sformatf("[FAIL] %0t ns: broadcast on tag %0d, which is not outstanding",
                            $time, got));
   endtask

   // expected ALU result where shifts use the low five bits of the second operand
   function automatic ooo_pkg::word_t ref_alu(input ooo_pkg::opcode_t op,
                                              input ooo_pkg::word_t a, input ooo_pkg::word_t b);
      logic [63:0] wide;
      int          sh;
      sh   = int'(b[4:0]);
      wide = {{32{a[31]}}, a} >> sh;
      case (op)
         ooo_pkg::OP_ADD:     return a + b;
         ooo_pkg::OP_SUB:     return a + ~b + 32'd1;
         ooo_pkg::OP_AND:     return a & b;
         ooo_pkg::OP_OR:      return a | b;
         ooo_pkg::OP_XOR:     return a ^ b;
         ooo_pkg::OP_SLL:     return a << sh;
         ooo_pkg::OP_SRL:     return a >> sh;
         ooo_pkg::OP_SRA:     return wide[31:0];
         ooo_pkg::OP_SLT:     return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
         ooo_pkg::OP_SLTU:    return {31'd0, a < b};
         ooo_pkg::OP_PASS_RS: return a;
         default:             return '0;
      endcase
   endfunction

   function automatic int count_busy();
      int n;
      n = 0;
      foreach (busy[i]) begin
         if (busy[i]) n++;
      end
      return n;
   endfunction

   // round robin keeps recently used tags away from reuse
   task automatic alloc_tag(output int t);
      t = 0;
      for (int n = 0; n < 63 && t == 0; n++) begin
         next_tag = next_tag % 63 + 1;
         if (!busy[next_tag]) t = next_tag;
      end
      if (t == 0) stop_run("no free tag left for a new producer");
      busy[t] = 1'b1;
   endtask

   task automatic new_ext(output int t);
      alloc_tag(t);
      val[t] = $random(seed);
      ext_q.push_back(t);
   endtask

   task automatic drive_ext();
      int t;
      ext_cdb_valid = 1'b0;
      if (ext_hold > 0) begin
         ext_hold--;
      end else if (ext_q.size() > 0 && $unsigned($random(seed)) % 100 < release_pct) begin
         t = ext_q.pop_front();
         ext_cdb_tag   = ooo_pkg::tag_t'(t);
         ext_cdb_data  = val[t];
         ext_cdb_valid = 1'b1;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         dispatch_en = 1'b0;
         drive_ext();
      end
   endtask

   // a source still pending goes out as a tag, a resolved one as its value
   task automatic set_operand(input int src, input ooo_pkg::word_t value,
                              output ooo_pkg::tag_t tag, output ooo_pkg::word_t data,
                              output logic valid);
      valid = !(src != 0 && busy[src]);
      tag   = valid ? '0 : ooo_pkg::tag_t'(src);
      data  = valid ? value : '0;
   endtask

   // source 0 takes the immediate, otherwise the value of the producer tag
   task automatic dispatch_one(input ooo_pkg::opcode_t op, input int rs, input int rt,
                               input ooo_pkg::word_t rs_imm, input ooo_pkg::word_t rt_imm,
                               output int rd);
      ooo_pkg::word_t a;
      ooo_pkg::word_t b;
      a = (rs == 0) ? rs_imm : val[rs];
      b = (rt == 0) ? rt_imm : val[rt];
      alloc_tag(rd);
      val[rd] = ref_alu(op, a, b);
      history.push_back(rd);
      if (history.size() > 8) void'(history.pop_front());
      n_disp++;
      do begin
         @(posedge clk);
         #1;
         drive_ext();
         dispatch_opcode = op;
         dispatch_rd_tag = ooo_pkg::tag_t'(rd);
         set_operand(rs, a, dispatch_rs_tag, dispatch_rs_data, dispatch_rs_valid);
         set_operand(rt, b, dispatch_rt_tag, dispatch_rt_data, dispatch_rt_valid);
         dispatch_en = 1'b1;
         @(negedge clk);
         saw_full = saw_full | ~dispatch_ready;
      end while (!dispatch_ready);
   endtask

   task automatic pick_source(output int s);
      int r;
      r = $unsigned($random(seed)) % 8;
      s = 0;
      if (r == 3) new_ext(s);
      else if (r > 3) s = history[$unsigned($random(seed)) % history.size()];
   endtask

   task automatic drain();
      ext_hold    = 0;
      release_pct = 100;
      do idle(1); while (count_busy() != 0);
   endtask

   always @(negedge clk) begin
      if (rst_n && cdb_valid) begin
         check_tag(cdb_tag);
         check_word(cdb_tag, cdb_data, val[cdb_tag]);
         busy[cdb_tag] = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * n_disp + 200)
         stop_run($sformatf("timeout: results still missing after %0d cycles", cycles));
   end

   initial begin
      int t1, t2, t3, e1, e2, rs, rt;
      ooo_pkg::opcode_t op;
      foreach (busy[i]) busy[i] = 1'b0;
      {dispatch_rd_tag, dispatch_rs_tag, dispatch_rt_tag, ext_cdb_tag} = '0;
      {dispatch_rs_data, dispatch_rt_data, ext_cdb_data} = '0;
      {dispatch_rs_valid, dispatch_rt_valid, dispatch_en, ext_cdb_valid} = '0;
      dispatch_opcode = ooo_pkg::OP_ADD;
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;

      // independent instructions including one unused opcode
      for (int i = 0; i < 12; i++)
         dispatch_one(ooo_pkg::opcode_t'(i), 0, 0, $random(seed), $random(seed), t1);
      drain();

      // chains on earlier ALU results
      dispatch_one(ooo_pkg::OP_ADD, 0, 0, 32'd7, 32'd5, t1);
      dispatch_one(ooo_pkg::OP_SUB, t1, 0, 0, 32'd3, t2);
      dispatch_one(ooo_pkg::OP_SLL, t2, t1, 0, 0, t3);
      dispatch_one(ooo_pkg::OP_XOR, t3, t2, 0, 0, t1);
      drain();

      // external wake-up, then a broadcast in the dispatch cycle itself
      ext_hold = 4;
      new_ext(e1);
      dispatch_one(ooo_pkg::OP_ADD, e1, 0, 0, 32'd1, t1);
      dispatch_one(ooo_pkg::OP_OR, e1, t1, 0, 0, t2);
      drain();
      new_ext(e2);
      dispatch_one(ooo_pkg::OP_SUB, e2, 0, 0, 32'd9, t3);
      drain();

      // every entry waits on one external tag until the queue is full
      saw_full = 1'b0;
      new_ext(e1);
      ext_hold = QUEUE_DEPTH + 6;
      for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
         dispatch_one(ooo_pkg::OP_ADD, e1, 0, 0, i, t1);
         if (i < QUEUE_DEPTH && saw_full)
            stop_run("dispatch_ready went low before the queue was full");
      end
      if (!saw_full) stop_run("dispatch_ready stayed high while the queue was full");
      drain();

      // external broadcast lands while the ALU holds a result
      ext_hold = 100;
      new_ext(e1);
      dispatch_one(ooo_pkg::OP_AND, 0, 0, $random(seed), $random(seed), t1);
      idle(1);
      ext_hold = 0;
      drain();

      release_pct = 30;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         op = ooo_pkg::opcode_t'($unsigned($random(seed)) % 16);
         pick_source(rs);
         pick_source(rt);
         dispatch_one(op, rs, rt, $random(seed), $random(seed), t1);
      end
      drain();

      if (count_busy() == 0 && ext_q.size() == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         stop_run("some tags were never broadcast");
      end
   end

endmodule

//--- verilog/cdb_if.sv
`timescale 1ns/10ps

// merged common data bus, valid is a one cycle strobe per result
interface cdb_if;

   ooo_pkg::tag_t  tag;
   ooo_pkg::word_t data;
   logic           valid;

   modport source (
      output tag, data, valid
   );

   modport sink (
      input tag, data, valid
   );

endinterface

//--- verilog/int_alu.sv
`timescale 1ns/10ps

module int_alu (
   input  logic           clk,
   input  logic           rst_n,

   issue_if.alu           issue,

   input  ooo_pkg::tag_t  ext_cdb_tag,
   input  ooo_pkg::word_t ext_cdb_data,
   input  logic           ext_cdb_valid,

   cdb_if.source          cdb
);

   ooo_pkg::tag_t  res_tag;
   ooo_pkg::word_t res_data;
   logic           res_valid;
   logic           res_drain;
   logic           issue_fire;
   ooo_pkg::word_t alu_out;

   function automatic ooo_pkg::word_t alu_compute(
      input ooo_pkg::opcode_t op,
      input ooo_pkg::word_t   a,
      input ooo_pkg::word_t   b
   );
      ooo_pkg::word_t r;
      logic [ooo_pkg::SHAMT_W-1:0] shamt;
      shamt = b[ooo_pkg::SHAMT_W-1:0];
      r     = '0;
      case (op)
         ooo_pkg::OP_ADD:     r = a + b;
         ooo_pkg::OP_SUB:     r = a - b;
         ooo_pkg::OP_AND:     r = a & b;
         ooo_pkg::OP_OR:      r = a | b;
         ooo_pkg::OP_XOR:     r = a ^ b;
         ooo_pkg::OP_SLL:     r = a << shamt;
         ooo_pkg::OP_SRL:     r = a >> shamt;
         ooo_pkg::OP_SRA:     r = $signed(a) >>> shamt;
         ooo_pkg::OP_SLT:     r[0] = $signed(a) < $signed(b);
         ooo_pkg::OP_SLTU:    r[0] = a < b;
         ooo_pkg::OP_PASS_RS: r = a;
         default:             r = '0;
      endcase
      return r;
   endfunction

   assign alu_out = alu_compute(issue.opcode, issue.rs_data, issue.rt_data);

   // the held result leaves only in a cycle without an external broadcast
   assign res_drain = res_valid & ~ext_cdb_valid;

   // a new instruction fits when the register is free or empties now
   assign issue.done = issue.ready & (~res_valid | res_drain);
   assign issue_fire = issue.ready & issue.done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else if (issue_fire) begin
         res_valid <= 1'b1;
      end else if (res_drain) begin
         res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_fire) begin
         res_tag  <= issue.rd_tag;
         res_data <= alu_out;
      end
   end

   // external producer has priority on the merged bus
   assign cdb.valid = ext_cdb_valid | res_valid;
   assign cdb.tag   = ext_cdb_valid ? ext_cdb_tag  : res_tag;
   assign cdb.data  = ext_cdb_valid ? ext_cdb_data : res_data;

endmodule

//--- verilog/int_exec_top.sv
`timescale 1ns/10ps

module int_exec_top #(
   parameter int QUEUE_DEPTH = ooo_pkg::QUEUE_DEPTH_DEFAULT
) (
   input  logic             clk,
   input  logic             rst_n,

   input  ooo_pkg::opcode_t dispatch_opcode,
   input  ooo_pkg::tag_t    dispatch_rd_tag,
   input  ooo_pkg::tag_t    dispatch_rs_tag,
   input  ooo_pkg::tag_t    dispatch_rt_tag,
   input  ooo_pkg::word_t   dispatch_rs_data,
   input  ooo_pkg::word_t   dispatch_rt_data,
   input  logic             dispatch_rs_valid,
   input  logic             dispatch_rt_valid,
   input  logic             dispatch_en,
   output logic             dispatch_ready,

   input  ooo_pkg::tag_t    ext_cdb_tag,
   input  ooo_pkg::word_t   ext_cdb_data,
   input  logic             ext_cdb_valid,

   output ooo_pkg::tag_t    cdb_tag,
   output ooo_pkg::word_t   cdb_data,
   output logic             cdb_valid
);

   issue_if issue_bus ();
   cdb_if   cdb_bus ();

   int_issue_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .clk               (clk),
      .rst_n             (rst_n),
      .dispatch_opcode   (dispatch_opcode),
      .dispatch_rd_tag   (dispatch_rd_tag),
      .dispatch_rs_tag   (dispatch_rs_tag),
      .dispatch_rt_tag   (dispatch_rt_tag),
      .dispatch_rs_data  (dispatch_rs_data),
      .dispatch_rt_data  (dispatch_rt_data),
      .dispatch_rs_valid (dispatch_rs_valid),
      .dispatch_rt_valid (dispatch_rt_valid),
      .dispatch_en       (dispatch_en),
      .dispatch_ready    (dispatch_ready),
      .issue             (issue_bus.queue),
      .cdb               (cdb_bus.sink)
   );

   int_alu u_alu (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue         (issue_bus.alu),
      .ext_cdb_tag   (ext_cdb_tag),
      .ext_cdb_data  (ext_cdb_data),
      .ext_cdb_valid (ext_cdb_valid),
      .cdb           (cdb_bus.source)
   );

   // merged bus is visible outside for result checking
   assign cdb_tag   = cdb_bus.tag;
   assign cdb_data  = cdb_bus.data;
   assign cdb_valid = cdb_bus.valid;

endmodule

//--- verilog/int_issue_queue.sv
`timescale 1ns/10ps

module int_issue_queue #(
   parameter int QUEUE_DEPTH = ooo_pkg::QUEUE_DEPTH_DEFAULT
) (
   input  logic             clk,
   input  logic             rst_n,

   input  ooo_pkg::opcode_t dispatch_opcode,
   input  ooo_pkg::tag_t    dispatch_rd_tag,
   input  ooo_pkg::tag_t    dispatch_rs_tag,
   input  ooo_pkg::tag_t    dispatch_rt_tag,
   input  ooo_pkg::word_t   dispatch_rs_data,
   input  ooo_pkg::word_t   dispatch_rt_data,
   input  logic             dispatch_rs_valid,
   input  logic             dispatch_rt_valid,
   input  logic             dispatch_en,
   output logic             dispatch_ready,

   issue_if.queue           issue,
   cdb_if.sink              cdb
);

   // stored entries, entry 0 is the oldest one
   ooo_pkg::opcode_t        q_opcode  [QUEUE_DEPTH];
   ooo_pkg::tag_t           q_rd_tag  [QUEUE_DEPTH];
   ooo_pkg::tag_t           q_rs_tag  [QUEUE_DEPTH];
   ooo_pkg::tag_t           q_rt_tag  [QUEUE_DEPTH];
   ooo_pkg::word_t          q_rs_data [QUEUE_DEPTH];
   ooo_pkg::word_t          q_rt_data [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0]  q_rs_valid;
   logic [QUEUE_DEPTH-1:0]  q_rt_valid;
   logic [QUEUE_DEPTH-1:0]  q_valid;

   // entries after snooping the CDB, with the dispatch input acting as
   // an extra entry on top that has no storage of its own
   ooo_pkg::opcode_t        s_opcode  [QUEUE_DEPTH+1];
   ooo_pkg::tag_t           s_rd_tag  [QUEUE_DEPTH+1];
   ooo_pkg::tag_t           s_rs_tag  [QUEUE_DEPTH+1];
   ooo_pkg::tag_t           s_rt_tag  [QUEUE_DEPTH+1];
   ooo_pkg::word_t          s_rs_data [QUEUE_DEPTH+1];
   ooo_pkg::word_t          s_rt_data [QUEUE_DEPTH+1];
   logic [QUEUE_DEPTH:0]    s_rs_valid;
   logic [QUEUE_DEPTH:0]    s_rt_valid;
   logic [QUEUE_DEPTH:0]    s_valid;

   logic [QUEUE_DEPTH-1:0]  sel;
   logic [QUEUE_DEPTH:0]    removed;
   logic [QUEUE_DEPTH-1:0]  shift;
   logic                    issue_fire;
   logic                    accept;

   assign issue_fire = issue.ready & issue.done;
   assign accept     = dispatch_en & dispatch_ready;

   // full only when every slot is taken and nothing leaves this cycle
   assign dispatch_ready = ~(&q_valid) | issue_fire;

   always_comb begin
      logic rs_hit;
      logic rt_hit;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         s_opcode[i]   = q_opcode[i];
         s_rd_tag[i]   = q_rd_tag[i];
         s_rs_tag[i]   = q_rs_tag[i];
         s_rt_tag[i]   = q_rt_tag[i];
         s_rs_data[i]  = q_rs_data[i];
         s_rt_data[i]  = q_rt_data[i];
         s_rs_valid[i] = q_rs_valid[i];
         s_rt_valid[i] = q_rt_valid[i];
         s_valid[i]    = q_valid[i];
      end
      s_opcode[QUEUE_DEPTH]   = dispatch_opcode;
      s_rd_tag[QUEUE_DEPTH]   = dispatch_rd_tag;
      s_rs_tag[QUEUE_DEPTH]   = dispatch_rs_tag;
      s_rt_tag[QUEUE_DEPTH]   = dispatch_rt_tag;
      s_rs_data[QUEUE_DEPTH]  = dispatch_rs_data;
      s_rt_data[QUEUE_DEPTH]  = dispatch_rt_data;
      s_rs_valid[QUEUE_DEPTH] = dispatch_rs_valid;
      s_rt_valid[QUEUE_DEPTH] = dispatch_rt_valid;
      s_valid[QUEUE_DEPTH]    = accept;

      // only an operand that is still pending takes the broadcast value
      for (int i = 0; i <= QUEUE_DEPTH; i++) begin
         rs_hit = cdb.valid && !s_rs_valid[i] && (cdb.tag == s_rs_tag[i]);
         rt_hit = cdb.valid && !s_rt_valid[i] && (cdb.tag == s_rt_tag[i]);
         if (rs_hit) begin
            s_rs_data[i]  = cdb.data;
            s_rs_valid[i] = 1'b1;
         end
         if (rt_hit) begin
            s_rt_data[i]  = cdb.data;
            s_rt_valid[i] = 1'b1;
         end
      end
   end

   // oldest entry with both operands present wins
   // the pick looks at stored state, so a wake-up counts from the next cycle
   always_comb begin
      logic found;
      found = 1'b0;
      sel   = '0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (!found && q_valid[i] && q_rs_valid[i] && q_rt_valid[i]) begin
            sel[i] = 1'b1;
            found  = 1'b1;
         end
      end
   end

   always_comb begin
      issue.ready   = |sel;
      issue.opcode  = q_opcode[0];
      issue.rd_tag  = q_rd_tag[0];
      issue.rs_data = q_rs_data[0];
      issue.rt_data = q_rt_data[0];
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (sel[i]) begin
            issue.opcode  = q_opcode[i];
            issue.rd_tag  = q_rd_tag[i];
            issue.rs_data = q_rs_data[i];
            issue.rt_data = q_rt_data[i];
         end
      end
   end

   assign removed = {1'b0, sel & {QUEUE_DEPTH{issue_fire}}};

   // a slot pulls from the one above once it is empty, is issued, or
   // a slot below it is already pulling
   always_comb begin
      logic carry;
      carry = 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         carry    = carry | ~q_valid[i] | removed[i];
         shift[i] = carry;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_valid    <= '0;
         q_rs_valid <= '0;
         q_rt_valid <= '0;
      end else begin
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (shift[i]) begin
               // an entry issued this cycle must not slide down as well
               q_valid[i]    <= s_valid[i+1] & ~removed[i+1];
               q_rs_valid[i] <= s_rs_valid[i+1];
               q_rt_valid[i] <= s_rt_valid[i+1];
            end else begin
               q_valid[i]    <= s_valid[i];
               q_rs_valid[i] <= s_rs_valid[i];
               q_rt_valid[i] <= s_rt_valid[i];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         q_opcode[i]  <= shift[i] ? s_opcode[i+1]  : s_opcode[i];
         q_rd_tag[i]  <= shift[i] ? s_rd_tag[i+1]  : s_rd_tag[i];
         q_rs_tag[i]  <= shift[i] ? s_rs_tag[i+1]  : s_rs_tag[i];
         q_rt_tag[i]  <= shift[i] ? s_rt_tag[i+1]  : s_rt_tag[i];
         q_rs_data[i] <= shift[i] ? s_rs_data[i+1] : s_rs_data[i];
         q_rt_data[i] <= shift[i] ? s_rt_data[i+1] : s_rt_data[i];
      end
   end

endmodule

//--- verilog/issue_if.sv
`timescale 1ns/10ps

// one selected instruction travelling from the issue queue to the ALU
// the transfer happens in a cycle where ready and done are both high
interface issue_if;

   ooo_pkg::opcode_t opcode;
   ooo_pkg::tag_t    rd_tag;
   ooo_pkg::word_t   rs_data;
   ooo_pkg::word_t   rt_data;
   logic             ready;
   logic             done;

   modport queue (
      output opcode, rd_tag, rs_data, rt_data, ready,
      input  done
   );

   modport alu (
      input  opcode, rd_tag, rs_data, rt_data, ready,
      output done
   );

endinterface

//--- verilog/ooo_pkg.sv
package ooo_pkg;

   // field widths shared by the queue, the ALU and the buses
   localparam int TAG_W    = 6;
   localparam int WORD_W   = 32;
   localparam int OPCODE_W = 4;

   // shift amounts only use the low bits of the second operand
   localparam int SHAMT_W  = $clog2(WORD_W);

   // default number of reservation entries in the issue queue
   localparam int QUEUE_DEPTH_DEFAULT = 4;

   // rename tag, zero means the operand has no pending producer
   typedef logic [TAG_W-1:0] tag_t;

   // operand and result word
   typedef logic [WORD_W-1:0] word_t;

   // integer ALU operations
   // codes above OP_PASS_RS are unused and give a zero result
   typedef enum logic [OPCODE_W-1:0] {
      OP_ADD     = 4'h0,
      OP_SUB     = 4'h1,
      OP_AND     = 4'h2,
      OP_OR      = 4'h3,
      OP_XOR     = 4'h4,
      OP_SLL     = 4'h5,
      OP_SRL     = 4'h6,
      OP_SRA     = 4'h7,
      OP_SLT     = 4'h8,
      OP_SLTU    = 4'h9,
      OP_PASS_RS = 4'hA
   } opcode_t;

endpackage
